// File: verilog.f
soc_pkg.sv
system_bus.sv
tcm_ram.sv
mtimer.sv
gpio_regs.sv
soc_periph_top.sv
soc_periph_sva.sv
tb_soc_periph.sv

// File: Makefile
TOP = tb_soc_periph

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// File: tb_soc_periph.sv
`timescale 1ns/100ps
// Directed testbench for the SoC peripheral subsystem
// Acts as the bus manager and checks RAM, unmapped space, GPIO and timer

module tb_soc_periph;
  import soc_pkg::*;

  localparam int MEM_SIZE_BYTES  = 4096;
  localparam int GPIO_WIDTH      = 8;
  localparam int NUM_WORDS       = MEM_SIZE_BYTES / 4;
  localparam int RAM_WRITES      = 16;
  localparam int TIMER_GAP       = 10;
  localparam int EST_TEST_CYCLES = 600;
  // About three times the directed test length plus reset margin
  localparam int TIMEOUT_CYCLES  = 3 * EST_TEST_CYCLES + 200;

  logic                  clock = 1'b0;
  logic                  rst_n;
  bus_req_t              req;
  bus_rsp_t              rsp;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_oe;
  logic                  timer_irq;
  logic [31:0]           lfsr_state;
  int                    cycles;

  soc_periph_top #(
    .MEM_SIZE_BYTES(MEM_SIZE_BYTES),
    .GPIO_WIDTH    (GPIO_WIDTH)
  ) soc_periph_top_inst (
    .clock    (clock),
    .rst_n    (rst_n),
    .req      (req),
    .gpio_in  (gpio_in),
    .rsp      (rsp),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .timer_irq(timer_irq)
  );

  initial begin
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles", cycles);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped");
    end
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic logic [31:0] ram_addr(input logic [9:0] idx);
    return RAM_BASE + {20'h0, idx, 2'b00};
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_gpio(input string name, input logic [GPIO_WIDTH-1:0] exp,
                            input logic [GPIO_WIDTH-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Bus tasks start and end on a falling edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    req = '{addr: addr, wdata: data, wstrb: strb, read: 1'b0, write: 1'b1};
    @(negedge clock);
    req = '0;
    if (rsp.ready !== 1'b1) begin
      stop_with_failure($sformatf("no response one cycle after write to %h", addr));
    end
  endtask

  task automatic bus_read(input logic [31:0] addr, output bus_rsp_t result);
    req = '{addr: addr, wdata: 32'h0, wstrb: 4'h0, read: 1'b1, write: 1'b0};
    @(negedge clock);
    req = '0;
    result = rsp;
    if (rsp.ready !== 1'b1) begin
      stop_with_failure($sformatf("no response one cycle after read of %h", addr));
    end
  endtask

  task automatic test_reset();
    bus_rsp_t r;
    check_rsp("reset_rsp", '0, rsp);
    check_word("reset_irq", 32'h0, {31'h0, timer_irq});
    check_gpio("reset_gpio_out", '0, gpio_out);
    check_gpio("reset_gpio_oe", '0, gpio_oe);
    bus_read(MTIMER_BASE + 32'(MTIMECMP_LO_OFS), r);
    check_rsp("reset_mtimecmp_lo", '{rdata: 32'hffff_ffff, ready: 1'b1}, r);
    bus_read(MTIMER_BASE + 32'(MTIMECMP_HI_OFS), r);
    check_rsp("reset_mtimecmp_hi", '{rdata: 32'hffff_ffff, ready: 1'b1}, r);
  endtask

  task automatic test_ram();
    logic [31:0] model [NUM_WORDS];
    logic [9:0]  word_idx [RAM_WRITES];
    logic [31:0] rnd;
    logic [31:0] data;
    logic [3:0]  strb;
    bus_rsp_t    r;
    for (int i = 0; i < RAM_WRITES; i++) begin
      rnd = rand_bits(10);
      word_idx[i] = rnd[9:0];
      data = rand_bits(32);
      model[word_idx[i]] = data;
      bus_write(ram_addr(word_idx[i]), data, 4'hf);
    end
    // Partial overwrite of every other word
    for (int i = 0; i < RAM_WRITES; i += 2) begin
      rnd = rand_bits(4);
      strb = rnd[3:0];
      data = rand_bits(32);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model[word_idx[i]][8*b +: 8] = data[8*b +: 8];
        end
      end
      bus_write(ram_addr(word_idx[i]), data, strb);
    end
    for (int i = 0; i < RAM_WRITES / 2; i++) begin
      bus_read(ram_addr(word_idx[i]), r);
      check_rsp("ram_read", '{rdata: model[word_idx[i]], ready: 1'b1}, r);
    end
    // Back-to-back reads, one issued while the previous one is answered
    for (int i = RAM_WRITES / 2; i <= RAM_WRITES; i++) begin
      if (i < RAM_WRITES) begin
        req = '{addr: ram_addr(word_idx[i]), wdata: 32'h0, wstrb: 4'h0,
                read: 1'b1, write: 1'b0};
      end else begin
        req = '0;
      end
      if (i > RAM_WRITES / 2) begin
        check_rsp("ram_burst", '{rdata: model[word_idx[i-1]], ready: 1'b1}, rsp);
      end
      @(negedge clock);
    end
  endtask

  task automatic test_unmapped();
    bus_rsp_t r;
    // Both unmapped addresses alias RAM word 0 in their low bits
    bus_write(RAM_BASE, 32'h5a5a_c3c3, 4'hf);
    bus_write(32'h4000_0000, 32'hdead_beef, 4'hf);
    bus_write(RAM_BASE + 32'(MEM_SIZE_BYTES), 32'h1234_5678, 4'hf);
    bus_read(32'h4000_0000, r);
    check_rsp("unmapped_low", '{rdata: 32'h0, ready: 1'b1}, r);
    bus_read(RAM_BASE + 32'(MEM_SIZE_BYTES), r);
    check_rsp("unmapped_past_ram", '{rdata: 32'h0, ready: 1'b1}, r);
    bus_read(RAM_BASE, r);
    check_rsp("unmapped_ram_intact", '{rdata: 32'h5a5a_c3c3, ready: 1'b1}, r);
  endtask

  task automatic test_gpio();
    logic [31:0] out_val;
    logic [31:0] oe_val;
    logic [31:0] in_val;
    bus_rsp_t    r;
    out_val = rand_bits(GPIO_WIDTH);
    oe_val = rand_bits(GPIO_WIDTH);
    bus_write(GPIO_BASE + 32'(GPIO_OUT_OFS), out_val, 4'hf);
    bus_write(GPIO_BASE + 32'(GPIO_OE_OFS), oe_val, 4'hf);
    // Strobe on an unused byte leaves the register alone
    bus_write(GPIO_BASE + 32'(GPIO_OUT_OFS), 32'hffff_ffff, 4'b0010);
    check_gpio("gpio_out_pins", out_val[GPIO_WIDTH-1:0], gpio_out);
    check_gpio("gpio_oe_pins", oe_val[GPIO_WIDTH-1:0], gpio_oe);
    bus_read(GPIO_BASE + 32'(GPIO_OUT_OFS), r);
    check_rsp("gpio_out_read", '{rdata: out_val, ready: 1'b1}, r);
    bus_read(GPIO_BASE + 32'(GPIO_OE_OFS), r);
    check_rsp("gpio_oe_read", '{rdata: oe_val, ready: 1'b1}, r);
    in_val = rand_bits(GPIO_WIDTH);
    gpio_in = in_val[GPIO_WIDTH-1:0];
    repeat (3) @(negedge clock);
    bus_read(GPIO_BASE + 32'(GPIO_IN_OFS), r);
    check_rsp("gpio_in_read", '{rdata: in_val, ready: 1'b1}, r);
  endtask

  task automatic test_timer();
    logic [31:0] t0;
    logic [31:0] t1;
    bus_rsp_t    r;
    bus_read(MTIMER_BASE + 32'(MTIME_LO_OFS), r);
    t0 = r.rdata;
    repeat (TIMER_GAP) @(negedge clock);
    bus_read(MTIMER_BASE + 32'(MTIME_LO_OFS), r);
    t1 = r.rdata;
    if ((t1 - t0) < 32'(TIMER_GAP)) begin
      stop_with_failure($sformatf("error: timer_count expected at least %0d actual %0d",
                                  TIMER_GAP, t1 - t0));
    end
    bus_read(MTIMER_BASE + 32'(MTIME_HI_OFS), r);
    check_rsp("mtime_hi", '{rdata: 32'h0, ready: 1'b1}, r);
    bus_read(MTIMER_BASE + 32'(MTIME_LO_OFS), r);
    bus_write(MTIMER_BASE + 32'(MTIMECMP_HI_OFS), 32'h0, 4'hf);
    bus_write(MTIMER_BASE + 32'(MTIMECMP_LO_OFS), r.rdata + 32'd20, 4'hf);
    check_word("irq_before_match", 32'h0, {31'h0, timer_irq});
    repeat (30) @(negedge clock);
    check_word("irq_after_match", 32'h1, {31'h0, timer_irq});
    bus_write(MTIMER_BASE + 32'(MTIMECMP_LO_OFS), 32'hffff_ffff, 4'hf);
    bus_write(MTIMER_BASE + 32'(MTIMECMP_HI_OFS), 32'hffff_ffff, 4'hf);
    check_word("irq_cleared", 32'h0, {31'h0, timer_irq});
  endtask

  initial begin
    lfsr_state = 32'ha35b_6bff;
    rst_n = 1'b0;
    req = '0;
    gpio_in = '0;
    repeat (2) @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);
    test_reset();
    test_ram();
    test_unmapped();
    test_gpio();
    test_timer();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: soc_periph_sva.sv
`timescale 1ns/100ps
// Bus handshake assertions
// Bound to the system bus to watch request pulses, response pulses and device select

module soc_periph_sva (
  input logic                            clock,
  input logic                            rst_n,
  input soc_pkg::bus_req_t               req,
  input soc_pkg::bus_rsp_t               rsp,
  input logic [soc_pkg::NUM_DEVICES-1:0] dev_sel
);

  read_write_exclusive: assert property (
    @(posedge clock) disable iff (!rst_n) !(req.read && req.write)
  ) else $error("read and write requested in the same cycle");

  // Every request is answered on the following cycle
  request_answered: assert property (
    @(posedge clock) disable iff (!rst_n) (req.read || req.write) |=> rsp.ready
  ) else $error("request without a response one cycle later");

  ready_has_request: assert property (
    @(posedge clock) disable iff (!rst_n) rsp.ready |-> $past(req.read || req.write)
  ) else $error("response pulse with no request in the previous cycle");

  select_onehot: assert property (
    @(posedge clock) disable iff (!rst_n) $onehot0(dev_sel)
  ) else $error("more than one device selected");

endmodule

bind system_bus soc_periph_sva soc_periph_sva_inst (
  .clock  (clock),
  .rst_n  (rst_n),
  .req    (req),
  .rsp    (rsp),
  .dev_sel(dev_sel)
);

// File: soc_periph_top.sv
`timescale 1ns/100ps
// SoC peripheral subsystem top level
// Joins the system bus to the data memory, machine timer and GPIO block

module soc_periph_top #(
  parameter int MEM_SIZE_BYTES = 4096,
  parameter int GPIO_WIDTH     = 8
) (
  input  logic                  clock,
  input  logic                  rst_n,
  input  soc_pkg::bus_req_t     req,
  input  logic [GPIO_WIDTH-1:0] gpio_in,
  output soc_pkg::bus_rsp_t     rsp,
  output logic [GPIO_WIDTH-1:0] gpio_out,
  output logic [GPIO_WIDTH-1:0] gpio_oe,
  output logic                  timer_irq
);
  import soc_pkg::*;

  // Bus to device wiring
  bus_req_t                    dev_req;
  logic [NUM_DEVICES-1:0]      dev_sel;
  bus_rsp_t [NUM_DEVICES-1:0]  dev_rsp;

  system_bus #(
    .MEM_SIZE_BYTES(MEM_SIZE_BYTES)
  ) system_bus_inst (
    .clock  (clock),
    .rst_n  (rst_n),
    .req    (req),
    .dev_rsp(dev_rsp),
    .rsp    (rsp),
    .dev_req(dev_req),
    .dev_sel(dev_sel)
  );

  tcm_ram #(
    .MEM_SIZE_BYTES(MEM_SIZE_BYTES)
  ) tcm_ram_inst (
    .clock(clock),
    .rst_n(rst_n),
    .sel  (dev_sel[DEV_RAM]),
    .req  (dev_req),
    .rsp  (dev_rsp[DEV_RAM])
  );

  mtimer mtimer_inst (
    .clock(clock),
    .rst_n(rst_n),
    .sel  (dev_sel[DEV_MTIMER]),
    .req  (dev_req),
    .rsp  (dev_rsp[DEV_MTIMER]),
    .irq  (timer_irq)
  );

  gpio_regs #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) gpio_regs_inst (
    .clock   (clock),
    .rst_n   (rst_n),
    .sel     (dev_sel[DEV_GPIO]),
    .req     (dev_req),
    .gpio_in (gpio_in),
    .rsp     (dev_rsp[DEV_GPIO]),
    .gpio_out(gpio_out),
    .gpio_oe (gpio_oe)
  );

endmodule

// File: gpio_regs.sv
`timescale 1ns/100ps
// GPIO block
// Output and output-enable registers plus a two-flop synchronised input

module gpio_regs #(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  sel,
  input  soc_pkg::bus_req_t     req,
  input  logic [GPIO_WIDTH-1:0] gpio_in,
  output soc_pkg::bus_rsp_t     rsp,
  output logic [GPIO_WIDTH-1:0] gpio_out,
  output logic [GPIO_WIDTH-1:0] gpio_oe
);
  import soc_pkg::*;

  bus_addr_u             addr_u;
  logic                  wr;
  logic                  rd;
  logic [GPIO_WIDTH-1:0] in_meta;
  logic [GPIO_WIDTH-1:0] in_sync;
  logic [31:0]           out_wr;
  logic [31:0]           oe_wr;
  logic [31:0]           rdata_d;
  logic [31:0]           rdata_q;
  logic                  ready_q;

  assign addr_u = req.addr;
  assign wr     = sel & req.write;
  assign rd     = sel & req.read;

  // Strobed merge on the zero-extended register value
  assign out_wr = apply_wstrb(32'(gpio_out), req.wdata, req.wstrb);
  assign oe_wr  = apply_wstrb(32'(gpio_oe), req.wdata, req.wstrb);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      in_meta  <= '0;
      in_sync  <= '0;
      gpio_out <= '0;
      gpio_oe  <= '0;
      ready_q  <= 1'b0;
    end else begin
      in_meta <= gpio_in;
      in_sync <= in_meta;
      ready_q <= sel;
      if (wr && addr_u.io.ofs == GPIO_OUT_OFS) begin
        gpio_out <= out_wr[GPIO_WIDTH-1:0];
      end
      if (wr && addr_u.io.ofs == GPIO_OE_OFS) begin
        gpio_oe <= oe_wr[GPIO_WIDTH-1:0];
      end
    end
  end

  // Upper bits above GPIO_WIDTH read as zero
  always_comb begin
    case (addr_u.io.ofs)
      GPIO_IN_OFS:  rdata_d = 32'(in_sync);
      GPIO_OUT_OFS: rdata_d = 32'(gpio_out);
      GPIO_OE_OFS:  rdata_d = 32'(gpio_oe);
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: mtimer.sv
`timescale 1ns/100ps
// Machine timer
// Free-running 64-bit mtime, 64-bit mtimecmp and a registered timer interrupt

module mtimer (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              sel,
  input  soc_pkg::bus_req_t req,
  output soc_pkg::bus_rsp_t rsp,
  output logic              irq
);
  import soc_pkg::*;

  bus_addr_u   addr_u;
  logic        wr;
  logic        rd;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        ready_q;

  assign addr_u = req.addr;
  assign wr     = sel & req.write;
  assign rd     = sel & req.read;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      mtime    <= '0;
      mtimecmp <= '1;
      irq      <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      ready_q <= sel;
      irq     <= (mtime >= mtimecmp);

      // A write to either mtime half replaces this cycle's increment
      if (wr && addr_u.io.ofs == MTIME_LO_OFS) begin
        mtime <= {mtime[63:32], apply_wstrb(mtime[31:0], req.wdata, req.wstrb)};
      end else if (wr && addr_u.io.ofs == MTIME_HI_OFS) begin
        mtime <= {apply_wstrb(mtime[63:32], req.wdata, req.wstrb), mtime[31:0]};
      end else begin
        mtime <= mtime + 64'd1;
      end

      if (wr && addr_u.io.ofs == MTIMECMP_LO_OFS) begin
        mtimecmp[31:0] <= apply_wstrb(mtimecmp[31:0], req.wdata, req.wstrb);
      end
      if (wr && addr_u.io.ofs == MTIMECMP_HI_OFS) begin
        mtimecmp[63:32] <= apply_wstrb(mtimecmp[63:32], req.wdata, req.wstrb);
      end
    end
  end

  // Register read mux
  always_comb begin
    case (addr_u.io.ofs)
      MTIME_LO_OFS:    rdata_d = mtime[31:0];
      MTIME_HI_OFS:    rdata_d = mtime[63:32];
      MTIMECMP_LO_OFS: rdata_d = mtimecmp[31:0];
      MTIMECMP_HI_OFS: rdata_d = mtimecmp[63:32];
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: tcm_ram.sv
`timescale 1ns/100ps
// Tightly coupled data memory
// Word array with byte-strobe writes and a one-cycle read response

module tcm_ram #(
  parameter int MEM_SIZE_BYTES = 4096
) (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              sel,
  input  soc_pkg::bus_req_t req,
  output soc_pkg::bus_rsp_t rsp
);
  import soc_pkg::*;

  localparam int NUM_WORDS = MEM_SIZE_BYTES / 4;
  localparam int IDX_W     = $clog2(NUM_WORDS);

  logic [31:0]      mem [NUM_WORDS];
  bus_addr_u        addr_u;
  logic [IDX_W-1:0] idx;
  logic [31:0]      rdata_q;
  logic             ready_q;

  assign addr_u = req.addr;
  assign idx    = addr_u.ram.word[IDX_W-1:0];

  always_ff @(posedge clock) begin
    if (sel && req.write) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
    if (sel && req.read) begin
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= sel;
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: system_bus.sv
`timescale 1ns/100ps
// System bus
// Decodes each manager request to one device and steers the response back

module system_bus #(
  parameter int MEM_SIZE_BYTES = 4096
) (
  input  logic                                         clock,
  input  logic                                         rst_n,
  input  soc_pkg::bus_req_t                            req,
  input  soc_pkg::bus_rsp_t [soc_pkg::NUM_DEVICES-1:0] dev_rsp,
  output soc_pkg::bus_rsp_t                            rsp,
  output soc_pkg::bus_req_t                            dev_req,
  output logic [soc_pkg::NUM_DEVICES-1:0]              dev_sel
);
  import soc_pkg::*;

  bus_addr_u              addr_u;
  logic [NUM_DEVICES-1:0] hit;
  logic                   access;
  logic [NUM_DEVICES-1:0] sel_q;
  logic                   unmapped_q;
  logic                   read_q;

  assign addr_u = req.addr;
  assign access = req.read | req.write;

  // RAM may span more than one io region, so match on the full word
  assign hit[DEV_RAM] = (req.addr - RAM_BASE) < 32'(MEM_SIZE_BYTES);

  assign hit[DEV_MTIMER] = (addr_u.io.region == MTIMER_BASE[31:16]) &&
                           ({addr_u.io.pad, addr_u.io.ofs} < 16'(PERIPH_REGION_BYTES));

  assign hit[DEV_GPIO] = (addr_u.io.region == GPIO_BASE[31:16]) &&
                         ({addr_u.io.pad, addr_u.io.ofs} < 16'(PERIPH_REGION_BYTES));

  // Same request goes to every device, the select picks the target
  assign dev_req = req;
  assign dev_sel = hit & {NUM_DEVICES{access}};

  // Record of the previous selection
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      sel_q      <= '0;
      unmapped_q <= 1'b0;
      read_q     <= 1'b0;
    end else begin
      sel_q      <= dev_sel;
      unmapped_q <= access & ~|hit;
      read_q     <= req.read;
    end
  end

  always_comb begin
    rsp = '0;
    for (int i = 0; i < NUM_DEVICES; i++) begin
      if (sel_q[i]) begin
        rsp = dev_rsp[i];
      end
    end
    // Unmapped accesses answer on their own with zero data
    if (unmapped_q) begin
      rsp.ready = 1'b1;
    end
    // Writes carry no data back
    if (!read_q) begin
      rsp.rdata = '0;
    end
  end

endmodule

// File: soc_pkg.sv
// SoC peripheral package
// Memory map, bus request and response types and the shared address decoding

package soc_pkg;

  // Manager request, one cycle wide
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        read;
    logic        write;
  } bus_req_t;

  // Device or bus response, ready is a single-cycle pulse
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } bus_rsp_t;

  // Peripheral view of an address
  typedef struct packed {
    logic [15:0] region;
    logic [10:0] pad;
    logic [4:0]  ofs;
  } io_addr_t;

  // Memory view of an address
  typedef struct packed {
    logic [29:0] word;
    logic [1:0]  byte_ofs;
  } ram_addr_t;

  typedef union packed {
    io_addr_t  io;
    ram_addr_t ram;
  } bus_addr_u;

  localparam int NUM_DEVICES = 3;
  localparam int DEV_RAM     = 0;
  localparam int DEV_MTIMER  = 1;
  localparam int DEV_GPIO    = 2;

  localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
  localparam logic [31:0] MTIMER_BASE = 32'h8001_0000;
  localparam logic [31:0] GPIO_BASE   = 32'h8002_0000;

  localparam int PERIPH_REGION_BYTES = 32;

  localparam logic [4:0] MTIME_LO_OFS    = 5'd0;
  localparam logic [4:0] MTIME_HI_OFS    = 5'd4;
  localparam logic [4:0] MTIMECMP_LO_OFS = 5'd8;
  localparam logic [4:0] MTIMECMP_HI_OFS = 5'd12;

  localparam logic [4:0] GPIO_IN_OFS  = 5'd0;
  localparam logic [4:0] GPIO_OUT_OFS = 5'd4;
  localparam logic [4:0] GPIO_OE_OFS  = 5'd8;

  // Replace the bytes of a register word selected by the write strobe
  function automatic logic [31:0] apply_wstrb(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  wstrb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage
